/* bench/mslope_cases.txt */
# level rundown_delay led_value, all hex
# one conversion per line, comparator flips rundown_delay cycles into rundown
1 0 3
0 0 4
1 5 7
0 7 1
1 c 2
0 1f 6
1 40 5
0 2 0
1 3 fffff9
0 a 12
1 1 6
0 19 3
1 80 4
0 11 7
1 22 1
0 4 2
1 9 5
0 33 6

/* bench/mslope_props.sv */
/*
  bound checks on the switch codes, the interrupt pulse and the latch level
*/
module mslope_props (
  input logic clk,
  input logic rst_n,
  input logic [2:0] mux,
  input logic int_n,
  input logic cmpr_latch_ctl
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertion attempts
  int fail_count = 0;

  // only the three legal switch codes
  mux_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
      (mux == mslope_pkg::mux_idle) || (mux == mslope_pkg::mux_down) ||
      (mux == mslope_pkg::mux_up)
  )
  else
  begin
    fail_count++;
    $error("switch code %b is not a legal code", mux);
  end

  // interrupt is a single cycle pulse
  int_single: assert property (
    @(posedge clk) disable iff (!rst_n)
      !int_n |=> int_n
  )
  else
  begin
    fail_count++;
    $error("interrupt held low for more than one cycle");
  end

  // latch stays enabled once the first init wait ends
  latch_stays: assert property (
    @(posedge clk) disable iff (!rst_n)
      !cmpr_latch_ctl |=> !cmpr_latch_ctl
  )
  else
  begin
    fail_count++;
    $error("comparator latch control rose again");
  end

endmodule

bind mslope_top mslope_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .mux            (mux),
  .int_n          (int_n),
  .cmpr_latch_ctl (cmpr_latch_ctl)
);

/* bench/mslope_tb.sv */
/*
  testbench of the multislope controller, runs one conversion per case line
  and checks results, led register and serial readback
*/
module mslope_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic clk;
  logic rst_n;
  logic cmpr_out;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic int_p_ctl;
  logic int_n_ctl;
  logic int_sig_ctl;
  logic cmpr_latch_ctl;
  logic miso;
  logic int_n;
  logic [2:0] led;

  integer seed;
  int errors;
  int checks;
  int cases_run;
  logic timed_out;

  mslope_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmpr_out       (cmpr_out),
    .sclk           (sclk),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .int_p_ctl      (int_p_ctl),
    .int_n_ctl      (int_n_ctl),
    .int_sig_ctl    (int_sig_ctl),
    .cmpr_latch_ctl (cmpr_latch_ctl),
    .miso           (miso),
    .int_n          (int_n),
    .led            (led)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_count(input string name, input logic [mslope_pkg::cnt_w-1:0] got,
                             input logic [mslope_pkg::cnt_w-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // replay fixed down, slot, fixed up and slot per cycle, then the rundown
  task automatic replay_counts(input logic lvl,
                               output logic [mslope_pkg::cnt_w-1:0] up,
                               output logic [mslope_pkg::cnt_w-1:0] down,
                               output logic [mslope_pkg::cnt_w-1:0] tu,
                               output logic [mslope_pkg::cnt_w-1:0] td);
    logic [2:0] dir;
    logic [2:0] last;
    logic [2:0] code;
    logic slot;
    int p;
    dir = lvl ? mslope_pkg::mux_up : mslope_pkg::mux_down;
    last = mslope_pkg::mux_idle;
    up = '0;
    down = '0;
    tu = '0;
    td = '0;
    for (p = 0; p <= 4 * mslope_pkg::num_osc; p++)
    begin
      slot = 1'b1;
      code = dir;
      if (p < 4 * mslope_pkg::num_osc)
      begin
        case (p % 4)
          0:
          begin
            code = mslope_pkg::mux_down;
            slot = 1'b0;
          end
          2:
          begin
            code = mslope_pkg::mux_up;
            slot = 1'b0;
          end
          default:
            code = dir;
        endcase
      end
      if (slot && code == mslope_pkg::mux_up)
        up++;
      if (slot && code == mslope_pkg::mux_down)
        down++;
      // transitions counted by the new direction
      if (code != last && code == mslope_pkg::mux_up)
        tu++;
      if (code != last && code == mslope_pkg::mux_down)
        td++;
      last = code;
    end
  endtask

  //////////////////////////////
  // serial host
  //////////////////////////////

  // sends the address byte and 24 data bits msb first and takes miso before each rise
  task automatic spi_frame(input mslope_pkg::reg_addr_t addr,
                           input logic [mslope_pkg::cnt_w-1:0] wdata,
                           output logic [mslope_pkg::cnt_w-1:0] rdata);
    logic [mslope_pkg::frame_bits-1:0] frame;
    int half;
    int i;
    frame = {addr.raw, wdata};
    half = 4 + ($unsigned($random(seed)) % 4);
    rdata = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    sclk <= 1'b0;
    for (i = mslope_pkg::frame_bits - 1; i >= 0; i--)
    begin
      @(posedge clk);
      mosi <= frame[i];
      repeat (half) @(posedge clk);
      if (i < mslope_pkg::cnt_w)
        rdata = {rdata[mslope_pkg::cnt_w-2:0], miso};
      sclk <= 1'b1;
      repeat (half) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (half) @(posedge clk);
    cs_n <= 1'b1;
    // let the deselect pass the sync flops
    repeat (6) @(posedge clk);
  endtask

  task automatic read_reg(input logic [mslope_pkg::addr_bits-2:0] index,
                          output logic [mslope_pkg::cnt_w-1:0] rdata);
    mslope_pkg::reg_addr_t addr;
    addr.split.no_write = 1'b1;
    addr.split.index = index;
    spi_frame(addr, '0, rdata);
  endtask

  //////////////////////////////
  // one conversion
  //////////////////////////////

  task automatic run_case(input logic lvl, input int delay,
                          input logic [mslope_pkg::cnt_w-1:0] led_val);
    logic [mslope_pkg::cnt_w-1:0] exp_up;
    logic [mslope_pkg::cnt_w-1:0] exp_down;
    logic [mslope_pkg::cnt_w-1:0] exp_tu;
    logic [mslope_pkg::cnt_w-1:0] exp_td;
    logic [mslope_pkg::cnt_w-1:0] rd;
    mslope_pkg::reg_addr_t addr;
    int k;

    // comparator settles at the case level during reset
    @(posedge clk);
    rst_n <= 1'b0;
    cmpr_out <= lvl;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_led("mux after reset", {int_sig_ctl, int_n_ctl, int_p_ctl}, mslope_pkg::mux_idle);
    check_level("int_n after reset", int_n, 1'b1);
    check_level("cmpr_latch_ctl after reset", cmpr_latch_ctl, 1'b1);

    // count cycles from reset release to the first switch change
    k = 0;
    while (!timed_out && ({int_sig_ctl, int_n_ctl, int_p_ctl} == mslope_pkg::mux_idle))
    begin
      if (k > 4 * mslope_pkg::init_cycles)
        report_timeout("first switch change");
      else
      begin
        @(posedge clk);
        k++;
        @(negedge clk);
      end
    end
    if (timed_out)
      return;
    check_count("init length", k, mslope_pkg::init_cycles + 1);
    check_level("cmpr_latch_ctl after init", cmpr_latch_ctl, 1'b0);

    // rundown starts after num_osc full four-phase cycles
    k = mslope_pkg::num_osc * (mslope_pkg::fix_pos_cycles + mslope_pkg::fix_neg_cycles +
        2 * mslope_pkg::var_cycles + 4);
    repeat (k + delay) @(posedge clk);
    cmpr_out <= ~lvl;

    k = 0;
    @(negedge clk);
    while (!timed_out && int_n)
    begin
      if (k > 20)
        report_timeout("interrupt pulse");
      else
      begin
        @(negedge clk);
        k++;
      end
    end
    if (timed_out)
      return;

    replay_counts(lvl, exp_up, exp_down, exp_tu, exp_td);
    read_reg(mslope_pkg::reg_up, rd);
    check_count("reg_up", rd, exp_up);
    read_reg(mslope_pkg::reg_down, rd);
    check_count("reg_down", rd, exp_down);
    read_reg(mslope_pkg::reg_trans_up, rd);
    check_count("reg_trans_up", rd, exp_tu);
    read_reg(mslope_pkg::reg_trans_down, rd);
    check_count("reg_trans_down", rd, exp_td);
    // crossing flagged three cycles after the pin flips
    read_reg(mslope_pkg::reg_rundown, rd);
    check_count("reg_rundown", rd, delay + 3);

    // led write followed by a read-only frame with other data
    addr.raw = {1'b0, mslope_pkg::reg_led};
    spi_frame(addr, led_val, rd);
    check_led("led after write", led, led_val[2:0]);
    addr.split.no_write = 1'b1;
    spi_frame(addr, ~led_val, rd);
    check_led("led after read-only frame", led, led_val[2:0]);
    check_count("reg_led readback", rd, {21'd0, led_val[2:0]});

    // soft preset on raw address 11
    addr.raw = {1'b0, mslope_pkg::reg_rundown};
    spi_frame(addr, '0, rd);
    check_led("led after soft reset", led, 3'b101);

    read_reg(mslope_pkg::reg_test, rd);
    check_count("reg_test", rd, 24'hffffff);
    read_reg(7'h33, rd);
    check_count("unknown index", rd, 24'h000000);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    integer fd;
    string line;
    int n;
    int lvl;
    int delay;
    int led_val;
    clk = 1'b0;
    rst_n = 1'b0;
    cmpr_out = 1'b0;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    seed = 32'hecb5;
    errors = 0;
    checks = 0;
    cases_run = 0;
    timed_out = 1'b0;

    fd = $fopen("bench/mslope_cases.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the cases file");
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        line = "";
        n = $fgets(line, fd);
        // skip comment and blank lines
        if (n > 0 && line.len() > 0 && line.getc(0) != "#")
        begin
          if ($sscanf(line, "%h %h %h", lvl, delay, led_val) == 3)
          begin
            run_case(lvl[0], delay, led_val[mslope_pkg::cnt_w-1:0]);
            cases_run++;
          end
        end
      end
      $fclose(fd);
      if (cases_run == 0)
      begin
        errors++;
        $display("no cases were read from the cases file");
      end
    end

    $display("%0d cases, %0d checks, %0d errors, %0d assertion failures",
             cases_run, checks, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* src/mslope_pkg.sv */
/*
  shared constants and types of the multislope converter controller
  phase lengths, switch codes, register map and the serial address byte
*/
package mslope_pkg;

  // width of every result count and of the rundown length
  localparam int cnt_w = 24;

  //////////////////////////////
  // phase lengths in clk cycles
  //////////////////////////////

  // idle wait before each conversion, integrator settles
  localparam int init_cycles = 40;
  localparam int fix_pos_cycles = 25;
  localparam int fix_neg_cycles = 20;
  // each variable phase, direction chosen by the comparator
  localparam int var_cycles = 100;
  // four-phase cycles per conversion, two variable slots in each
  localparam int num_osc = 4;

  // switch codes, bit order {sig, n, p}
  // signal switch is never closed here
  localparam logic [2:0] mux_idle = 3'b000;
  localparam logic [2:0] mux_down = 3'b001;
  localparam logic [2:0] mux_up = 3'b010;

  // sequencer states
  localparam logic [2:0] st_init = 3'd0;
  localparam logic [2:0] st_fix_pos = 3'd1;
  localparam logic [2:0] st_var1 = 3'd2;
  localparam logic [2:0] st_fix_neg = 3'd3;
  localparam logic [2:0] st_var2 = 3'd4;
  localparam logic [2:0] st_rundown = 3'd5;

  //////////////////////////////
  // serial register port
  //////////////////////////////

  // address byte then 24 data bits, msb first
  localparam int frame_bits = 32;
  localparam int addr_bits = 8;

  // register indices, the low 7 bits of the address byte
  localparam logic [addr_bits-2:0] reg_led = 7'd7;
  localparam logic [addr_bits-2:0] reg_up = 7'd9;
  localparam logic [addr_bits-2:0] reg_down = 7'd10;
  localparam logic [addr_bits-2:0] reg_rundown = 7'd11;
  localparam logic [addr_bits-2:0] reg_trans_up = 7'd12;
  localparam logic [addr_bits-2:0] reg_trans_down = 7'd14;
  localparam logic [addr_bits-2:0] reg_test = 7'd15;
  // write to 11 is a soft reset of the led register, reads give the rundown
  localparam logic [addr_bits-2:0] reg_soft_reset = 7'd11;

  // led value after a soft reset
  localparam logic [2:0] led_preset = 3'b101;

  // address byte, raw for write decode, split for read decode
  typedef union packed {
    logic [addr_bits-1:0] raw;
    struct packed {
      // set for a read-only frame
      logic no_write;
      logic [addr_bits-2:0] index;
    } split;
  } reg_addr_t;

endpackage

/* src/mslope_sequencer.sv */
/*
  multislope phase sequencer, steers the integrator switches through
  fixed and variable phases, then runs down to a comparator crossing
*/
module mslope_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic cmpr_out,
  output logic [2:0] mux,
  output logic cmpr_latch_ctl,
  output logic slot_strobe,
  output logic conv_done,
  output logic [mslope_pkg::cnt_w-1:0] rundown_len
);

  // comparator sync chain, last is the previous synced level
  logic cmpr_meta;
  logic cmpr_sync;
  logic cmpr_last;
  logic cross_any;
  // direction the comparator asks for right now
  logic [2:0] cmpr_dir;

  logic [2:0] state;
  // cycles since the current phase started
  logic [mslope_pkg::cnt_w-1:0] phase_cnt;
  // variable slots applied in this conversion
  logic [$clog2(2 * mslope_pkg::num_osc + 1)-1:0] slot_cnt;

  //////////////////////////////
  // comparator sync
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cmpr_meta <= 1'b0;
      cmpr_sync <= 1'b0;
      cmpr_last <= 1'b0;
    end
    else
    begin
      cmpr_meta <= cmpr_out;
      cmpr_sync <= cmpr_meta;
      cmpr_last <= cmpr_sync;
    end
  end

  // either edge, high while the second flop holds the new level
  assign cross_any = cmpr_sync ^ cmpr_last;

  // comparator high means integrator below zero, drive up
  assign cmpr_dir = cmpr_sync ? mslope_pkg::mux_up : mslope_pkg::mux_down;

  // crossing ends the rundown
  assign conv_done = (state == mslope_pkg::st_rundown) && cross_any;
  // rundown start cycle counts as the first one
  assign rundown_len = phase_cnt + 1'b1;

  //////////////////////////////
  // phase state machine
  //////////////////////////////

  // every phase holds for its length plus the start cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= mslope_pkg::st_init;
      phase_cnt <= '0;
      slot_cnt <= '0;
      mux <= mslope_pkg::mux_idle;
      cmpr_latch_ctl <= 1'b1;
      slot_strobe <= 1'b0;
    end
    else
    begin
      slot_strobe <= 1'b0;
      phase_cnt <= phase_cnt + 1'b1;
      case (state)
        mslope_pkg::st_init:
        begin
          if (phase_cnt == mslope_pkg::init_cycles)
          begin
            // wait over, comparator enabled for good
            state <= mslope_pkg::st_fix_pos;
            phase_cnt <= '0;
            slot_cnt <= '0;
            mux <= mslope_pkg::mux_down;
            cmpr_latch_ctl <= 1'b0;
          end
        end
        mslope_pkg::st_fix_pos:
        begin
          if (phase_cnt == mslope_pkg::fix_pos_cycles)
          begin
            // first variable slot of this cycle
            state <= mslope_pkg::st_var1;
            phase_cnt <= '0;
            slot_cnt <= slot_cnt + 1'b1;
            mux <= cmpr_dir;
            slot_strobe <= 1'b1;
          end
        end
        mslope_pkg::st_var1:
        begin
          if (phase_cnt == mslope_pkg::var_cycles)
          begin
            state <= mslope_pkg::st_fix_neg;
            phase_cnt <= '0;
            mux <= mslope_pkg::mux_up;
          end
        end
        mslope_pkg::st_fix_neg:
        begin
          if (phase_cnt == mslope_pkg::fix_neg_cycles)
          begin
            // second variable slot
            state <= mslope_pkg::st_var2;
            phase_cnt <= '0;
            slot_cnt <= slot_cnt + 1'b1;
            mux <= cmpr_dir;
            slot_strobe <= 1'b1;
          end
        end
        mslope_pkg::st_var2:
        begin
          if (phase_cnt == mslope_pkg::var_cycles)
          begin
            phase_cnt <= '0;
            if (slot_cnt == 2 * mslope_pkg::num_osc)
            begin
              // all slots done, rundown direction from the comparator
              state <= mslope_pkg::st_rundown;
              mux <= cmpr_dir;
              slot_strobe <= 1'b1;
            end
            else
            begin
              state <= mslope_pkg::st_fix_pos;
              mux <= mslope_pkg::mux_down;
            end
          end
        end
        mslope_pkg::st_rundown:
        begin
          if (cross_any)
          begin
            // zero crossing, open the switches and wait again
            state <= mslope_pkg::st_init;
            phase_cnt <= '0;
            mux <= mslope_pkg::mux_idle;
          end
        end
        default:
        begin
          state <= mslope_pkg::st_init;
          phase_cnt <= '0;
          mux <= mslope_pkg::mux_idle;
        end
      endcase
    end
  end

endmodule

/* src/mslope_tally.sv */
/*
  slot and transition tally, snapshots the counts and the rundown
  length into the result registers at each conversion end
*/
module mslope_tally (
  input  logic clk,
  input  logic rst_n,
  input  logic [2:0] mux,
  input  logic slot_strobe,
  input  logic conv_done,
  input  logic [mslope_pkg::cnt_w-1:0] rundown_len,
  output logic [mslope_pkg::cnt_w-1:0] count_up,
  output logic [mslope_pkg::cnt_w-1:0] count_down,
  output logic [mslope_pkg::cnt_w-1:0] count_rundown,
  output logic [mslope_pkg::cnt_w-1:0] count_trans_up,
  output logic [mslope_pkg::cnt_w-1:0] count_trans_down
);

  // switch code held in the previous cycle
  logic [2:0] last_dir;
  logic conv_start;

  // working counts of the running conversion
  logic [mslope_pkg::cnt_w-1:0] up_cnt;
  logic [mslope_pkg::cnt_w-1:0] down_cnt;
  logic [mslope_pkg::cnt_w-1:0] trans_up_cnt;
  logic [mslope_pkg::cnt_w-1:0] trans_down_cnt;

  // counts after this cycle
  logic [mslope_pkg::cnt_w-1:0] up_next;
  logic [mslope_pkg::cnt_w-1:0] down_next;
  logic [mslope_pkg::cnt_w-1:0] trans_up_next;
  logic [mslope_pkg::cnt_w-1:0] trans_down_next;

  // switches leave idle, a new conversion begins
  assign conv_start = (last_dir == mslope_pkg::mux_idle) && (mux != mslope_pkg::mux_idle);

  always_comb
  begin
    // start from zero on a new conversion
    up_next = conv_start ? '0 : up_cnt;
    down_next = conv_start ? '0 : down_cnt;
    trans_up_next = conv_start ? '0 : trans_up_cnt;
    trans_down_next = conv_start ? '0 : trans_down_cnt;

    // comparator decided slot, counted by the applied direction
    if (slot_strobe && (mux == mslope_pkg::mux_up))
      up_next = up_next + 1'b1;
    if (slot_strobe && (mux == mslope_pkg::mux_down))
      down_next = down_next + 1'b1;

    // direction change, also out of idle, fixed phases included
    if ((mux != last_dir) && (mux == mslope_pkg::mux_up))
      trans_up_next = trans_up_next + 1'b1;
    if ((mux != last_dir) && (mux == mslope_pkg::mux_down))
      trans_down_next = trans_down_next + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      last_dir <= mslope_pkg::mux_idle;
      up_cnt <= '0;
      down_cnt <= '0;
      trans_up_cnt <= '0;
      trans_down_cnt <= '0;
      count_up <= '0;
      count_down <= '0;
      count_rundown <= '0;
      count_trans_up <= '0;
      count_trans_down <= '0;
    end
    else
    begin
      last_dir <= mux;
      up_cnt <= up_next;
      down_cnt <= down_next;
      trans_up_cnt <= trans_up_next;
      trans_down_cnt <= trans_down_next;
      // snapshot, the host reads these until the next crossing
      if (conv_done)
      begin
        count_up <= up_next;
        count_down <= down_next;
        count_rundown <= rundown_len;
        count_trans_up <= trans_up_next;
        count_trans_down <= trans_down_next;
      end
    end
  end

endmodule

/* src/mslope_top.sv */
/*
  multislope converter controller top level
*/
module mslope_top (
  input  logic clk,
  input  logic rst_n,
  input  logic cmpr_out,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic int_p_ctl,
  output logic int_n_ctl,
  output logic int_sig_ctl,
  output logic cmpr_latch_ctl,
  output logic miso,
  output logic int_n,
  output logic [2:0] led
);

  // switch code and conversion events
  logic [2:0] mux;
  logic slot_strobe;
  logic conv_done;
  logic [mslope_pkg::cnt_w-1:0] rundown_len;

  // snapshot results
  logic [mslope_pkg::cnt_w-1:0] count_up;
  logic [mslope_pkg::cnt_w-1:0] count_down;
  logic [mslope_pkg::cnt_w-1:0] count_rundown;
  logic [mslope_pkg::cnt_w-1:0] count_trans_up;
  logic [mslope_pkg::cnt_w-1:0] count_trans_down;

  // switch pins in code order {sig, n, p}
  assign {int_sig_ctl, int_n_ctl, int_p_ctl} = mux;

  mslope_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmpr_out       (cmpr_out),
    .mux            (mux),
    .cmpr_latch_ctl (cmpr_latch_ctl),
    .slot_strobe    (slot_strobe),
    .conv_done      (conv_done),
    .rundown_len    (rundown_len)
  );

  mslope_tally u_tally (
    .clk              (clk),
    .rst_n            (rst_n),
    .mux              (mux),
    .slot_strobe      (slot_strobe),
    .conv_done        (conv_done),
    .rundown_len      (rundown_len),
    .count_up         (count_up),
    .count_down       (count_down),
    .count_rundown    (count_rundown),
    .count_trans_up   (count_trans_up),
    .count_trans_down (count_trans_down)
  );

  spi_reg_bank u_reg_bank (
    .clk              (clk),
    .rst_n            (rst_n),
    .sclk             (sclk),
    .cs_n             (cs_n),
    .mosi             (mosi),
    .miso             (miso),
    .conv_done        (conv_done),
    .count_up         (count_up),
    .count_down       (count_down),
    .count_rundown    (count_rundown),
    .count_trans_up   (count_trans_up),
    .count_trans_down (count_trans_down),
    .led              (led),
    .int_n            (int_n)
  );

endmodule

/* src/spi_reg_bank.sv */
/*
  serial register bank, oversamples the host frame in the clk domain,
  reads results and the led register, drives the interrupt pulse
*/
module spi_reg_bank (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  input  logic conv_done,
  input  logic [mslope_pkg::cnt_w-1:0] count_up,
  input  logic [mslope_pkg::cnt_w-1:0] count_down,
  input  logic [mslope_pkg::cnt_w-1:0] count_rundown,
  input  logic [mslope_pkg::cnt_w-1:0] count_trans_up,
  input  logic [mslope_pkg::cnt_w-1:0] count_trans_down,
  output logic [2:0] led,
  output logic int_n
);

  // pin sync chains, last flop for edge detect
  logic sclk_meta;
  logic sclk_sync;
  logic sclk_last;
  logic cs_meta;
  logic cs_sync;
  logic cs_last;
  logic mosi_meta;
  logic mosi_sync;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;

  // bits received, saturates well above a frame
  logic [$clog2(mslope_pkg::frame_bits):0] bit_cnt;
  logic [mslope_pkg::frame_bits-1:0] shift_in;
  logic [mslope_pkg::frame_bits-1:0] shift_next;
  logic [mslope_pkg::cnt_w-1:0] shift_out;
  logic [mslope_pkg::cnt_w-1:0] rd_value;

  // address as it completes, and as held at frame end
  mslope_pkg::reg_addr_t rd_addr;
  mslope_pkg::reg_addr_t wr_addr;

  //////////////////////////////
  // pin sync and interrupt
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_meta <= 1'b0;
      sclk_sync <= 1'b0;
      sclk_last <= 1'b0;
      cs_meta <= 1'b1;
      cs_sync <= 1'b1;
      cs_last <= 1'b1;
      int_n <= 1'b1;
    end
    else
    begin
      sclk_meta <= sclk;
      sclk_sync <= sclk_meta;
      sclk_last <= sclk_sync;
      cs_meta <= cs_n;
      cs_sync <= cs_meta;
      cs_last <= cs_sync;
      // one cycle low per conversion, active low
      int_n <= ~conv_done;
    end
  end

  assign sclk_rise = sclk_sync & ~sclk_last;
  assign sclk_fall = ~sclk_sync & sclk_last;
  assign cs_rise = cs_sync & ~cs_last;

  //////////////////////////////
  // frame shifter
  //////////////////////////////

  // mosi delayed like sclk so the sample lands mid bit
  always_ff @(posedge clk)
  begin
    mosi_meta <= mosi;
    mosi_sync <= mosi_meta;
    if (!cs_sync && sclk_rise)
      shift_in <= shift_next;
  end

  assign shift_next = {shift_in[mslope_pkg::frame_bits-2:0], mosi_sync};
  // low byte of the shifter once the 8th bit arrives
  assign rd_addr = shift_next[mslope_pkg::addr_bits-1:0];
  // top byte once the whole frame is in
  assign wr_addr = shift_in[mslope_pkg::frame_bits-1 -: mslope_pkg::addr_bits];

  // read mux, unknown index reads zero
  always_comb
  begin
    case (rd_addr.split.index)
      mslope_pkg::reg_led:
        rd_value = {{(mslope_pkg::cnt_w-3){1'b0}}, led};
      mslope_pkg::reg_up:
        rd_value = count_up;
      mslope_pkg::reg_down:
        rd_value = count_down;
      mslope_pkg::reg_rundown:
        rd_value = count_rundown;
      mslope_pkg::reg_trans_up:
        rd_value = count_trans_up;
      mslope_pkg::reg_trans_down:
        rd_value = count_trans_down;
      // fixed pattern for link checks
      mslope_pkg::reg_test:
        rd_value = '1;
      default:
        rd_value = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      shift_out <= '0;
      miso <= 1'b0;
      led <= '0;
    end
    else
    begin
      if (cs_sync)
      begin
        // deselected, frame restarts
        bit_cnt <= '0;
        shift_out <= '0;
        miso <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
        begin
          if (bit_cnt != '1)
            bit_cnt <= bit_cnt + 1'b1;
          // address complete, load the read value
          if (bit_cnt == mslope_pkg::addr_bits - 1)
            shift_out <= rd_value;
        end
        // host samples on rise, so miso moves after the fall
        if (sclk_fall)
        begin
          miso <= shift_out[mslope_pkg::cnt_w-1];
          shift_out <= {shift_out[mslope_pkg::cnt_w-2:0], 1'b0};
        end
      end

      // write decode on a complete frame only
      if (cs_rise && (bit_cnt == mslope_pkg::frame_bits) && !wr_addr.split.no_write)
      begin
        if (wr_addr.raw == {1'b0, mslope_pkg::reg_led})
          led <= shift_in[2:0];
        else if (wr_addr.raw == {1'b0, mslope_pkg::reg_soft_reset})
          led <= mslope_pkg::led_preset;
      end
    end
  end

endmodule

/* verilog.f */
src/mslope_pkg.sv
src/mslope_sequencer.sv
src/mslope_tally.sv
src/spi_reg_bank.sv
src/mslope_top.sv
bench/mslope_props.sv
bench/mslope_tb.sv
